// File: simd_alu_elem_pkg.sv
/* SIMD ALU element definitions
   Element width encoding and the datapath word and flag types */

package simd_alu_elem_pkg;

  // Datapath word width
  localparam int unsigned ElenWidth = 64;

  // Element width, log2 of the element size in bytes
  typedef enum logic [1:0] {
    EW8  = 2'b00,
    EW16 = 2'b01,
    EW32 = 2'b10,
    EW64 = 2'b11
  } vew_e;

  // One datapath word
  typedef logic [ElenWidth-1:0] elen_t;

  // Saturation flags, one per byte
  typedef logic [ElenWidth/8-1:0] vxsat_t;

endpackage

// File: simd_alu_op_pkg.sv
/* SIMD ALU opcodes
   Operation encoding and opcode groupings used across the datapath */

package simd_alu_op_pkg;

  typedef enum logic [4:0] {
    VAND   = 5'd0,
    VOR    = 5'd1,
    VXOR   = 5'd2,
    VADD   = 5'd3,
    VSUB   = 5'd4,
    VRSUB  = 5'd5,
    VSADDU = 5'd6,
    VSADD  = 5'd7,
    VSSUBU = 5'd8,
    VSSUB  = 5'd9,
    VSLL   = 5'd10,
    VSRL   = 5'd11,
    VSRA   = 5'd12,
    VMIN   = 5'd13,
    VMINU  = 5'd14,
    VMAX   = 5'd15,
    VMAXU  = 5'd16,
    VMSEQ  = 5'd17,
    VMSNE  = 5'd18,
    VMSLT  = 5'd19,
    VMSLTU = 5'd20,
    VMSLE  = 5'd21,
    VMSLEU = 5'd22
  } alu_op_e;

  // Saturating arithmetic, the only ops that raise vxsat
  function automatic logic is_sat_op(alu_op_e op);
    return op inside {VSADDU, VSADD, VSSUBU, VSSUB};
  endfunction

  // Compares and min/max that treat elements as signed
  function automatic logic is_signed_op(alu_op_e op);
    return op inside {VMIN, VMAX, VMSLT, VMSLE};
  endfunction

  function automatic logic is_max_op(alu_op_e op);
    return op inside {VMAX, VMAXU};
  endfunction

endpackage

// File: simd_alu_ctrl.sv
/* SIMD ALU handshake control
   Turns a four-phase req/ack transaction into capture and done pulses */

`timescale 1ns/1ps

module simd_alu_ctrl (
  input  logic clk_i,
  input  logic arst_n_i,
  input  logic req_i,
  output logic capture_o,
  output logic done_o,
  output logic ack_o
);

  typedef enum logic [1:0] {
    IDLE,
    BUSY,
    DONE
  } ctrl_state_e;

  ctrl_state_e state_q;
  ctrl_state_e state_d;
  logic        capture_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      // Leave once the operands are latched
      IDLE: if (capture_q) state_d = BUSY;
      BUSY: state_d = DONE;
      // Hold ack until the requester lets go
      DONE: if (!req_i) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q   <= IDLE;
      capture_q <= 1'b0;
    end else begin
      state_q   <= state_d;
      // Single pulse per request, req stays high through BUSY
      capture_q <= (state_q == IDLE) && req_i && !capture_q;
    end
  end

  assign capture_o = capture_q;
  assign done_o    = (state_q == BUSY);
  assign ack_o     = (state_q == DONE);

endmodule

// File: simd_alu_cmp.sv
/* SIMD ALU element comparator
   Per-element less-than and equality, signed or unsigned by opcode */

`timescale 1ns/1ps

module simd_alu_cmp
  import simd_alu_elem_pkg::*;
  import simd_alu_op_pkg::*;
#(
  parameter int unsigned DataWidth = 64
) (
  input  logic [DataWidth-1:0]   opa_i,
  input  logic [DataWidth-1:0]   opb_i,
  input  vew_e                   vew_i,
  input  alu_op_e                op_i,
  output logic [DataWidth/8-1:0] less_o,
  output logic [DataWidth/8-1:0] equal_o
);

  localparam int unsigned StrbWidth = DataWidth / 8;

  logic                      is_signed;
  logic [3:0][StrbWidth-1:0] less_w;
  logic [3:0][StrbWidth-1:0] equal_w;

  assign is_signed = is_signed_op(op_i);

  // One compare set per element width, result in the element's low byte
  for (genvar w = 0; w < 4; w++) begin : gen_width
    localparam int unsigned EW        = 8 << w;
    localparam int unsigned LaneBytes = EW / 8;

    for (genvar l = 0; l < DataWidth / EW; l++) begin : gen_lane
      logic [EW-1:0] a;
      logic [EW-1:0] b;
      logic          lt;

      assign a  = opa_i[l*EW +: EW];
      assign b  = opb_i[l*EW +: EW];
      // Extra top bit makes one signed compare serve both forms
      assign lt = $signed({is_signed & b[EW-1], b}) < $signed({is_signed & a[EW-1], a});

      assign less_w[w][l*LaneBytes +: LaneBytes]  = LaneBytes'(lt);
      assign equal_w[w][l*LaneBytes +: LaneBytes] = LaneBytes'(a == b);
    end
  end

  assign less_o  = less_w[vew_i];
  assign equal_o = equal_w[vew_i];

endmodule

// File: simd_alu_addsub.sv
/* SIMD ALU adder
   Wrapping and saturating add/subtract per element, with byte flags */

`timescale 1ns/1ps

module simd_alu_addsub
  import simd_alu_elem_pkg::*;
  import simd_alu_op_pkg::*;
#(
  parameter int unsigned DataWidth = 64
) (
  input  logic [DataWidth-1:0]   opa_i,
  input  logic [DataWidth-1:0]   opb_i,
  input  vew_e                   vew_i,
  input  alu_op_e                op_i,
  output logic [DataWidth-1:0]   sum_o,
  output logic [DataWidth/8-1:0] sat_o
);

  localparam int unsigned StrbWidth = DataWidth / 8;

  logic [3:0][DataWidth-1:0] sum_w;
  logic [3:0][StrbWidth-1:0] sat_w;

  for (genvar w = 0; w < 4; w++) begin : gen_width
    localparam int unsigned   EW        = 8 << w;
    localparam int unsigned   LaneBytes = EW / 8;
    localparam logic [EW-1:0] SMax      = {1'b0, {(EW-1){1'b1}}};
    localparam logic [EW-1:0] SMin      = {1'b1, {(EW-1){1'b0}}};

    for (genvar l = 0; l < DataWidth / EW; l++) begin : gen_lane
      logic [EW-1:0] a;
      logic [EW-1:0] b;
      logic [EW:0]   add;
      logic [EW:0]   sub;
      logic [EW-1:0] rsub;
      logic [EW-1:0] raw;
      logic [EW-1:0] clamp;
      logic          sat;

      assign a    = opa_i[l*EW +: EW];
      assign b    = opb_i[l*EW +: EW];
      // Top bit is the carry or borrow
      assign add  = {1'b0, a} + {1'b0, b};
      assign sub  = {1'b0, b} - {1'b0, a};
      assign rsub = a - b;

      always_comb begin
        case (op_i)
          VSUB, VSSUBU, VSSUB: raw = sub[EW-1:0];
          VRSUB:               raw = rsub;
          default:             raw = add[EW-1:0];
        endcase
      end

      ///////////////////////////////////////////////////////////////////
      // Saturation detect and clamp value
      ///////////////////////////////////////////////////////////////////

      always_comb begin
        sat   = 1'b0;
        clamp = '0;
        case (op_i)
          VSADDU: begin
            sat   = add[EW];
            clamp = '1;
          end
          // Unsigned underflow clamps to zero
          VSSUBU: sat = sub[EW];
          VSADD: begin
            sat   = (a[EW-1] == b[EW-1]) && (add[EW-1] != a[EW-1]);
            clamp = a[EW-1] ? SMin : SMax;
          end
          VSSUB: begin
            sat   = (a[EW-1] != b[EW-1]) && (sub[EW-1] != b[EW-1]);
            clamp = b[EW-1] ? SMin : SMax;
          end
          default: ;
        endcase
      end

      assign sum_w[w][l*EW +: EW]               = sat ? clamp : raw;
      assign sat_w[w][l*LaneBytes +: LaneBytes] = {LaneBytes{sat}};
    end
  end

  assign sum_o = sum_w[vew_i];
  assign sat_o = sat_w[vew_i];

endmodule

// File: simd_alu_shift.sv
/* SIMD ALU shifter
   Per-element logical left, logical right and arithmetic right shifts */

`timescale 1ns/1ps

module simd_alu_shift
  import simd_alu_elem_pkg::*;
  import simd_alu_op_pkg::*;
#(
  parameter int unsigned DataWidth = 64
) (
  input  logic [DataWidth-1:0] opa_i,
  input  logic [DataWidth-1:0] opb_i,
  input  vew_e                 vew_i,
  input  alu_op_e              op_i,
  output logic [DataWidth-1:0] shift_o
);

  logic [3:0][DataWidth-1:0] shift_w;

  for (genvar w = 0; w < 4; w++) begin : gen_width
    localparam int unsigned EW  = 8 << w;
    localparam int unsigned ShW = $clog2(EW);

    for (genvar l = 0; l < DataWidth / EW; l++) begin : gen_lane
      logic [EW-1:0]  b;
      logic [ShW-1:0] amt;
      logic [EW-1:0]  res;

      // Only the low log2(EW) bits of opa count
      assign amt = opa_i[l*EW +: ShW];
      assign b   = opb_i[l*EW +: EW];

      always_comb begin
        case (op_i)
          VSLL:    res = b << amt;
          VSRL:    res = b >> amt;
          VSRA:    res = $signed(b) >>> amt;
          default: res = '0;
        endcase
      end

      assign shift_w[w][l*EW +: EW] = res;
    end
  end

  assign shift_o = shift_w[vew_i];

endmodule

// File: simd_alu_result.sv
/* SIMD ALU result select
   Logic ops, min/max and compare bits, then the final word and flags by opcode */

`timescale 1ns/1ps

module simd_alu_result
  import simd_alu_elem_pkg::*;
  import simd_alu_op_pkg::*;
#(
  parameter int unsigned DataWidth = 64
) (
  input  alu_op_e                op_i,
  input  vew_e                   vew_i,
  input  logic [DataWidth-1:0]   opa_i,
  input  logic [DataWidth-1:0]   opb_i,
  input  logic [DataWidth/8-1:0] less_i,
  input  logic [DataWidth/8-1:0] equal_i,
  input  logic [DataWidth-1:0]   sum_i,
  input  logic [DataWidth/8-1:0] sat_i,
  input  logic [DataWidth-1:0]   shift_i,
  output logic [DataWidth-1:0]   result_o,
  output logic [DataWidth/8-1:0] vxsat_o
);

  localparam int unsigned StrbWidth = DataWidth / 8;

  logic                      is_max;
  logic [StrbWidth-1:0]      cmp_flag;
  logic [3:0][DataWidth-1:0] minmax_w;
  logic [3:0][DataWidth-1:0] cmp_w;

  assign is_max = is_max_op(op_i);

  // Compare outcome per byte, only each element's low byte is used
  always_comb begin
    case (op_i)
      VMSEQ:         cmp_flag = equal_i;
      VMSNE:         cmp_flag = ~equal_i;
      VMSLT, VMSLTU: cmp_flag = less_i;
      default:       cmp_flag = less_i | equal_i;
    endcase
  end

  for (genvar w = 0; w < 4; w++) begin : gen_width
    localparam int unsigned EW        = 8 << w;
    localparam int unsigned LaneBytes = EW / 8;

    for (genvar l = 0; l < DataWidth / EW; l++) begin : gen_lane
      // less means opb below opa, so min takes opb
      assign minmax_w[w][l*EW +: EW] = (less_i[l*LaneBytes] ^ is_max) ?
                                       opb_i[l*EW +: EW] : opa_i[l*EW +: EW];
      assign cmp_w[w][l*EW +: EW]    = EW'(cmp_flag[l*LaneBytes]);
    end
  end

  ///////////////////////////////////////////////////////////////////////
  // Final select
  ///////////////////////////////////////////////////////////////////////

  always_comb begin
    case (op_i)
      VAND: result_o = opa_i & opb_i;
      VOR:  result_o = opa_i | opb_i;
      VXOR: result_o = opa_i ^ opb_i;
      VADD, VSUB, VRSUB, VSADDU, VSADD, VSSUBU, VSSUB: result_o = sum_i;
      VSLL, VSRL, VSRA: result_o = shift_i;
      VMIN, VMINU, VMAX, VMAXU: result_o = minmax_w[vew_i];
      VMSEQ, VMSNE, VMSLT, VMSLTU, VMSLE, VMSLEU: result_o = cmp_w[vew_i];
      default: result_o = '0;
    endcase
  end

  assign vxsat_o = is_sat_op(op_i) ? sat_i : '0;

endmodule

// File: simd_alu_top.sv
/* SIMD ALU top level
   Four-phase req/ack wrapper around the element datapath with registered result */

`timescale 1ns/1ps

module simd_alu_top
  import simd_alu_elem_pkg::*;
  import simd_alu_op_pkg::*;
#(
  parameter int unsigned DataWidth = ElenWidth
) (
  input  logic    clk_i,
  input  logic    arst_n_i,
  input  logic    req_i,
  input  alu_op_e op_i,
  input  vew_e    vew_i,
  input  elen_t   operand_a_i,
  input  elen_t   operand_b_i,
  output logic    ack_o,
  output elen_t   result_o,
  output vxsat_t  vxsat_o
);

  localparam int unsigned StrbWidth = DataWidth / 8;

  logic                 capture;
  logic                 done;
  logic [DataWidth-1:0] opa_q;
  logic [DataWidth-1:0] opb_q;
  alu_op_e              op_q;
  vew_e                 vew_q;
  logic [StrbWidth-1:0] less;
  logic [StrbWidth-1:0] equal;
  logic [DataWidth-1:0] sum;
  logic [StrbWidth-1:0] sat;
  logic [DataWidth-1:0] shift;
  logic [DataWidth-1:0] res;
  logic [StrbWidth-1:0] vxsat;
  logic [DataWidth-1:0] result_q;
  logic [StrbWidth-1:0] vxsat_q;

  simd_alu_ctrl u_ctrl (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .req_i     (req_i),
    .capture_o (capture),
    .done_o    (done),
    .ack_o     (ack_o)
  );

  ///////////////////////////////////////////////////////////////////////
  // Operand capture
  ///////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (capture) begin
      opa_q <= operand_a_i;
      opb_q <= operand_b_i;
    end
  end

  // Opcode and element width for the datapath selects
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      op_q  <= VAND;
      vew_q <= EW8;
    end else if (capture) begin
      op_q  <= op_i;
      vew_q <= vew_i;
    end
  end

  simd_alu_cmp #(.DataWidth(DataWidth)) u_cmp (
    .opa_i   (opa_q),
    .opb_i   (opb_q),
    .vew_i   (vew_q),
    .op_i    (op_q),
    .less_o  (less),
    .equal_o (equal)
  );

  simd_alu_addsub #(.DataWidth(DataWidth)) u_addsub (
    .opa_i (opa_q),
    .opb_i (opb_q),
    .vew_i (vew_q),
    .op_i  (op_q),
    .sum_o (sum),
    .sat_o (sat)
  );

  simd_alu_shift #(.DataWidth(DataWidth)) u_shift (
    .opa_i   (opa_q),
    .opb_i   (opb_q),
    .vew_i   (vew_q),
    .op_i    (op_q),
    .shift_o (shift)
  );

  simd_alu_result #(.DataWidth(DataWidth)) u_result (
    .op_i     (op_q),
    .vew_i    (vew_q),
    .opa_i    (opa_q),
    .opb_i    (opb_q),
    .less_i   (less),
    .equal_i  (equal),
    .sum_i    (sum),
    .sat_i    (sat),
    .shift_i  (shift),
    .result_o (res),
    .vxsat_o  (vxsat)
  );

  // Result held from done until the next transaction completes
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      result_q <= '0;
      vxsat_q  <= '0;
    end else if (done) begin
      result_q <= res;
      vxsat_q  <= vxsat;
    end
  end

  assign result_o = result_q;
  assign vxsat_o  = vxsat_q;

endmodule

// File: tb_simd_alu_assert.sv
/* SIMD ALU handshake assertions
   Acknowledge latency, request ordering and result stability */

`timescale 1ns/1ps

module tb_simd_alu_assert
  import simd_alu_elem_pkg::*;
(
  input logic  clk_i,
  input logic  arst_n_i,
  input logic  req_i,
  input logic  ack_i,
  input elen_t result_i
);

  // Ack registers on the second edge after req, seen in the following sample
  property p_ack_latency;
    @(posedge clk_i) disable iff (!arst_n_i)
      $rose(req_i) |-> !ack_i [*3] ##1 ack_i;
  endproperty

  property p_ack_needs_req;
    @(posedge clk_i) disable iff (!arst_n_i)
      $rose(ack_i) |-> $past(req_i);
  endproperty

  property p_result_stable;
    @(posedge clk_i) disable iff (!arst_n_i)
      ack_i && $past(ack_i) |-> $stable(result_i);
  endproperty

  a_ack_latency: assert property (p_ack_latency)
    else $error("ack_o did not rise two cycles after req_i");

  a_ack_needs_req: assert property (p_ack_needs_req)
    else $error("ack_o rose while req_i was low");

  a_result_stable: assert property (p_result_stable)
    else $error("result_o changed while ack_o was high");

endmodule

bind simd_alu_top tb_simd_alu_assert u_assert (
  .clk_i    (clk_i),
  .arst_n_i (arst_n_i),
  .req_i    (req_i),
  .ack_i    (ack_o),
  .result_i (result_o)
);

// File: tb_simd_alu.sv
/* SIMD ALU testbench
   Directed req/ack tests checked against a per-element reference model */

`timescale 1ns/1ps

module tb_simd_alu
  import simd_alu_elem_pkg::*;
  import simd_alu_op_pkg::*;
();

  localparam int NumRand   = 4;
  localparam int NumCorner = 4;
  // Reset test, logic/wrap, saturating, shifts, min/max and compares, back-pressure
  localparam int NumTrans  = 1 + 6*4*NumRand + 4*4*(NumRand + NumCorner) + 3*4*NumRand
                           + 10*4*NumRand + 2;
  localparam int TimeoutCycles = NumTrans * 8 + 200;

  typedef enum logic [1:0] {
    IDLE,
    BUSY,
    DONE
  } ctrl_state_e;

  typedef logic signed [65:0] wide_t;

  logic        clk_i;
  logic        arst_n_i;
  logic        req_i;
  alu_op_e     op_i;
  vew_e        vew_i;
  elen_t       operand_a_i;
  elen_t       operand_b_i;
  logic        ack_o;
  elen_t       result_o;
  vxsat_t      vxsat_o;
  ctrl_state_e fsm_state;
  logic [31:0] lcg_state;
  int          error_count;
  int          check_count;
  int          cycle_count;
  string       txn_desc;

  simd_alu_top #(.DataWidth(ElenWidth)) u_simd_alu_top (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .req_i       (req_i),
    .op_i        (op_i),
    .vew_i       (vew_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .ack_o       (ack_o),
    .result_o    (result_o),
    .vxsat_o     (vxsat_o)
  );

  assign fsm_state = ctrl_state_e'(u_simd_alu_top.u_ctrl.state_q);

  always #4 clk_i = ~clk_i;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic elen_t rand_word();
    return {lcg_next(), lcg_next()};
  endfunction

  function automatic elen_t elem_mask(input int ew);
    return {ElenWidth{1'b1}} >> (ElenWidth - ew);
  endfunction

  function automatic wide_t extend(input elen_t x, input int ew, input logic sgn);
    wide_t v;
    v = wide_t'({2'b00, x});
    if (sgn && x[ew-1]) v = v | ~wide_t'({2'b00, elem_mask(ew)});
    return v;
  endfunction

  // Each element picks zero, one, unsigned max, signed max or signed min
  function automatic elen_t corner_operand(input vew_e vew);
    int    ew;
    elen_t mask;
    elen_t pick;
    elen_t v;
    ew   = 8 << vew;
    mask = elem_mask(ew);
    v    = '0;
    for (int l = 0; l < ElenWidth / ew; l++) begin
      case (lcg_next() % 5)
        0:       pick = '0;
        1:       pick = 1;
        2:       pick = mask;
        3:       pick = mask >> 1;
        default: pick = (mask >> 1) + 1;
      endcase
      v = v | ((pick & mask) << (l * ew));
    end
    return v;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  function automatic elen_t model_alu(input alu_op_e op, input vew_e vew, input elen_t a,
                                      input elen_t b, output vxsat_t sat);
    int    ew;
    int    amt;
    elen_t mask;
    elen_t ea;
    elen_t eb;
    elen_t r;
    elen_t res;
    logic  sgn;
    logic  flag;
    wide_t xa;
    wide_t xb;
    wide_t wide;
    wide_t lo;
    wide_t hi;
    ew   = 8 << vew;
    mask = elem_mask(ew);
    sgn  = op inside {VMIN, VMAX, VMSLT, VMSLE, VSADD, VSSUB, VSRA};
    res  = '0;
    sat  = '0;
    for (int l = 0; l < ElenWidth / ew; l++) begin
      ea   = (a >> (l * ew)) & mask;
      eb   = (b >> (l * ew)) & mask;
      xa   = extend(ea, ew, sgn);
      xb   = extend(eb, ew, sgn);
      amt  = int'(ea[5:0]) & (ew - 1);
      flag = 1'b0;
      case (op)
        VAND:  r = ea & eb;
        VOR:   r = ea | eb;
        VXOR:  r = ea ^ eb;
        VADD:  r = ea + eb;
        // Subtract takes opa from opb, reverse subtract the other way
        VSUB:  r = eb - ea;
        VRSUB: r = ea - eb;
        VSADDU, VSADD, VSSUBU, VSSUB: begin
          wide = (op inside {VSADDU, VSADD}) ? xa + xb : xb - xa;
          if (sgn) begin
            hi = wide_t'({2'b00, mask >> 1});
            lo = -hi - 1;
          end else begin
            hi = wide_t'({2'b00, mask});
            lo = 0;
          end
          flag = (wide > hi) || (wide < lo);
          if (wide > hi) r = hi[63:0];
          else if (wide < lo) r = lo[63:0];
          else r = wide[63:0];
        end
        VSLL: r = eb << amt;
        VSRL: r = eb >> amt;
        VSRA: begin
          wide = xb >>> amt;
          r    = wide[63:0];
        end
        VMIN, VMINU:     r = (xb < xa) ? eb : ea;
        VMAX, VMAXU:     r = (xb < xa) ? ea : eb;
        VMSEQ:           r = elen_t'(ea == eb);
        VMSNE:           r = elen_t'(ea != eb);
        VMSLT, VMSLTU:   r = elen_t'(xb < xa);
        VMSLE, VMSLEU:   r = elen_t'(xb <= xa);
        default:         r = '0;
      endcase
      res = res | ((r & mask) << (l * ew));
      if (flag) sat = sat | (vxsat_t'((1 << (ew / 8)) - 1) << (l * ew / 8));
    end
    return res;
  endfunction

  task automatic check_result(input string name, input elen_t got, input elen_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("error %s: got %h expected %h (%s)", name, got, exp, txn_desc);
    end
  endtask

  task automatic check_vxsat(input string name, input vxsat_t got, input vxsat_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("error %s: got %h expected %h (%s)", name, got, exp, txn_desc);
    end
  endtask

  task automatic check_ack(input string name, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("error %s: got %h expected %h (%s)", name, got, exp, txn_desc);
    end
  endtask

  // One full handshake, entered and left on a falling edge
  task automatic run_op(input alu_op_e op, input vew_e vew, input elen_t a, input elen_t b,
                        input int hold);
    elen_t  exp_res;
    vxsat_t exp_sat;
    int     lat;
    exp_res     = model_alu(op, vew, a, b, exp_sat);
    txn_desc    = $sformatf("%s %s", op.name(), vew.name());
    op_i        = op;
    vew_i       = vew;
    operand_a_i = a;
    operand_b_i = b;
    req_i       = 1'b1;
    lat         = 0;
    @(negedge clk_i);
    while (!ack_o && lat < 8) begin
      @(negedge clk_i);
      lat++;
    end
    if (!ack_o) begin
      error_count++;
      $display("%s: no acknowledge within 8 cycles of the request", txn_desc);
    end else if (lat != 2) begin
      error_count++;
      $display("%s: acknowledge came %0d cycles after the request, not 2", txn_desc, lat);
    end
    check_result("result_o", result_o, exp_res);
    check_vxsat("vxsat_o", vxsat_o, exp_sat);
    repeat (hold) begin
      @(negedge clk_i);
      check_ack("ack_o", ack_o, 1'b1);
      check_result("result_o", result_o, exp_res);
      check_vxsat("vxsat_o", vxsat_o, exp_sat);
    end
    req_i = 1'b0;
    @(negedge clk_i);
    check_ack("ack_o", ack_o, 1'b0);
    if (fsm_state != IDLE) begin
      error_count++;
      $display("%s: control FSM did not return to idle after release", txn_desc);
    end
  endtask

  task automatic sweep_widths(input alu_op_e op, input int n, input logic use_corner);
    elen_t a;
    elen_t b;
    for (int w = 0; w < 4; w++) begin
      for (int i = 0; i < n; i++) begin
        a = use_corner ? corner_operand(vew_e'(w)) : rand_word();
        b = use_corner ? corner_operand(vew_e'(w)) : rand_word();
        run_op(op, vew_e'(w), a, b, 0);
      end
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    $display("%-22s %s (%0d errors)", name,
             (error_count == errs_before) ? "ok" : "FAILED", error_count - errs_before);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_reset_handshake();
    int errs;
    errs     = error_count;
    txn_desc = "after reset";
    check_ack("ack_o", ack_o, 1'b0);
    check_result("result_o", result_o, '0);
    check_vxsat("vxsat_o", vxsat_o, '0);
    if (fsm_state != IDLE) begin
      error_count++;
      $display("control FSM not idle after reset");
    end
    run_op(VADD, EW32, rand_word(), rand_word(), 3);
    report_test("reset_handshake", errs);
  endtask

  task automatic test_logic_wrap();
    int errs;
    errs = error_count;
    sweep_widths(VAND, NumRand, 1'b0);
    sweep_widths(VOR, NumRand, 1'b0);
    sweep_widths(VXOR, NumRand, 1'b0);
    sweep_widths(VADD, NumRand, 1'b0);
    sweep_widths(VSUB, NumRand, 1'b0);
    sweep_widths(VRSUB, NumRand, 1'b0);
    report_test("logic_wrap", errs);
  endtask

  task automatic test_saturating();
    int errs;
    errs = error_count;
    sweep_widths(VSADDU, NumRand, 1'b0);
    sweep_widths(VSADD, NumRand, 1'b0);
    sweep_widths(VSSUBU, NumRand, 1'b0);
    sweep_widths(VSSUB, NumRand, 1'b0);
    sweep_widths(VSADDU, NumCorner, 1'b1);
    sweep_widths(VSADD, NumCorner, 1'b1);
    sweep_widths(VSSUBU, NumCorner, 1'b1);
    sweep_widths(VSSUB, NumCorner, 1'b1);
    report_test("saturating", errs);
  endtask

  task automatic test_shifts();
    int errs;
    errs = error_count;
    sweep_widths(VSLL, NumRand, 1'b0);
    sweep_widths(VSRL, NumRand, 1'b0);
    sweep_widths(VSRA, NumRand, 1'b0);
    report_test("shifts", errs);
  endtask

  task automatic test_minmax_compare();
    int errs;
    errs = error_count;
    sweep_widths(VMIN, NumRand, 1'b0);
    sweep_widths(VMINU, NumRand, 1'b0);
    sweep_widths(VMAX, NumRand, 1'b0);
    sweep_widths(VMAXU, NumRand, 1'b0);
    // Corner operands make equal elements likely
    sweep_widths(VMSEQ, NumRand, 1'b1);
    sweep_widths(VMSNE, NumRand, 1'b1);
    sweep_widths(VMSLT, NumRand, 1'b0);
    sweep_widths(VMSLTU, NumRand, 1'b0);
    sweep_widths(VMSLE, NumRand, 1'b1);
    sweep_widths(VMSLEU, NumRand, 1'b1);
    report_test("minmax_compare", errs);
  endtask

  task automatic test_back_pressure();
    int errs;
    errs = error_count;
    run_op(VSSUB, EW16, corner_operand(EW16), corner_operand(EW16), 20);
    run_op(VXOR, EW8, rand_word(), rand_word(), 0);
    report_test("back_pressure", errs);
  endtask

  initial begin
    clk_i       = 1'b0;
    arst_n_i    = 1'b0;
    req_i       = 1'b0;
    op_i        = VAND;
    vew_i       = EW8;
    operand_a_i = '0;
    operand_b_i = '0;
    lcg_state   = 32'h6b92_a23e;
    error_count = 0;
    check_count = 0;
    txn_desc    = "";
    repeat (10) @(negedge clk_i);
    arst_n_i = 1'b1;
    @(negedge clk_i);
    test_reset_handshake();
    test_logic_wrap();
    test_saturating();
    test_shifts();
    test_minmax_compare();
    test_back_pressure();
    $display("Checks run: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  initial begin : watchdog
    cycle_count = 0;
    while (cycle_count < TimeoutCycles) begin
      @(posedge clk_i);
      cycle_count++;
    end
    $display("Run stopped after %0d cycles, the tests did not complete", cycle_count);
    $display("Test failures found");
    $finish;
  end

endmodule

// File: flist.f
simd_alu_elem_pkg.sv
simd_alu_op_pkg.sv
simd_alu_ctrl.sv
simd_alu_cmp.sv
simd_alu_addsub.sv
simd_alu_shift.sv
simd_alu_result.sv
simd_alu_top.sv
tb_simd_alu_assert.sv
tb_simd_alu.sv
